//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_hwpe_regfile
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/hwpe_regfile_chk.sv
// Register file assertions
// Checks the read data after reset, the finished count range and
// the unused upper status bytes
`timescale 1ns/10ps

module hwpe_regfile_chk (
  input logic               clk_i,
  input logic               rst_ni,
  input regfile_pkg::data_t rdata_i,
  input logic [1:0]         finished_cnt_i,
  input regfile_pkg::data_t status_word_i
);
  import regfile_pkg::*;

  // Count of failed assertions
  int unsigned fail_count = 0;

  rdata_zero_after_reset: assert property (
    @(posedge clk_i) $rose(rst_ni) |-> (rdata_i == '0)
  ) else begin
    fail_count++;
    $error("rdata_o is not zero in the cycle after reset");
  end

  // Counter saturates at 2
  finished_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_ni) (finished_cnt_i <= 2'd2)
  ) else begin
    fail_count++;
    $error("finished count above 2");
  end

  status_upper_zero: assert property (
    @(posedge clk_i) disable iff (!rst_ni) (status_word_i[data_w-1:8*n_context] == '0)
  ) else begin
    fail_count++;
    $error("status byte of a missing context is set");
  end

endmodule

bind hwpe_regfile_top hwpe_regfile_chk i_hwpe_regfile_chk (
  .clk_i          ( clk_i        ),
  .rst_ni         ( rst_ni       ),
  .rdata_i        ( rdata_o      ),
  .finished_cnt_i ( finished_cnt ),
  .status_word_i  ( status_word  )
);

//--- dv/tb_hwpe_regfile.sv
// Testbench for the processing engine control register file
// Seeded random host and controller traffic checked every cycle
// against a cycle model of the register file
`timescale 1ns/10ps

module tb_hwpe_regfile;
  import regfile_pkg::*;

  localparam int unsigned max_cycles = 20000;

  logic      clk;
  logic      rst_n;
  logic      clear;
  bus_req_t  bus_req;
  ctrl_evt_t ctrl_evt;
  data_t     rdata;
  params_t   params;

  // Cycle model state
  data_t                m_mem [n_context][n_io_regs];
  logic [n_context-1:0] m_busy;
  logic [1:0]           m_fin;
  job_id_t              m_offload;
  job_id_t              m_running;
  logic                 m_done_q;
  data_t                m_rdata;
  string                m_rd_name;

  int unsigned err_count;
  int unsigned assert_fails;
  int unsigned check_count;
  int unsigned cycles;
  logic        seen_wrap;
  logic        seen_sat;
  logic        seen_collide;

  hwpe_regfile_top i_hwpe_regfile_top (
    .clk_i    ( clk      ),
    .rst_ni   ( rst_n    ),
    .clear_i  ( clear    ),
    .req_i    ( bus_req  ),
    .evt_i    ( ctrl_evt ),
    .rdata_o  ( rdata    ),
    .params_o ( params   )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic reg_class_t classify(reg_idx_t idx);
    if (idx == reg_trigger || idx == reg_softclear) return cls_zero;
    if (idx == reg_acquire) return cls_acquire;
    if (idx == reg_finished) return cls_finished;
    if (idx == reg_status) return cls_status;
    if (idx == reg_running_job) return cls_running;
    if (idx >= reg_idx_t'(8) && idx < reg_idx_t'(16)) return cls_io;
    return cls_unknown;
  endfunction

  task automatic reset_model();
    for (int c = 0; c < n_context; c++) begin
      for (int i = 0; i < n_io_regs; i++) begin
        m_mem[c][i] = '0;
      end
    end
    m_busy    = '0;
    m_fin     = '0;
    m_offload = '0;
    m_running = '0;
    m_done_q  = 1'b0;
    m_rdata   = '0;
    m_rd_name = "after reset or clear";
  endtask

  // Model reacts to the inputs the DUT samples at this edge
  task automatic update_model();
    reg_class_t cls;
    int         io;
    logic       rd;
    cls = classify(bus_req.addr.idx);
    io  = int'(bus_req.addr.idx) - 8;
    rd  = bus_req.req && !bus_req.we;
    if (clear) begin
      reset_model();
    end else begin
      if (rd) begin
        m_rd_name = $sformatf("read ctx %0d idx %0d", bus_req.addr.ctx, bus_req.addr.idx);
        case (cls)
          cls_acquire: begin
            if (ctrl_evt.is_critical) begin
              m_rdata = 32'hFFFF_FFFE;
            end else if (ctrl_evt.full_context) begin
              m_rdata = 32'hFFFF_FFFF;
            end else begin
              m_rdata = data_t'(m_offload);
              if (m_offload == 8'hFF) seen_wrap = 1'b1;
              m_offload = m_offload + 8'd1;
            end
          end
          cls_finished: begin
            m_rdata = data_t'(m_fin);
            if (m_fin == 2'd2) seen_sat = 1'b1;
          end
          cls_status: begin
            m_rdata = '0;
            for (int c = 0; c < n_context; c++) m_rdata[8*c] = m_busy[c];
          end
          cls_running: m_rdata = data_t'(m_running);
          cls_io:      m_rdata = m_mem[bus_req.addr.ctx][io];
          cls_unknown: m_rdata = 32'hDEAD_BEEF;
          default:     m_rdata = '0;
        endcase
      end
      if (bus_req.req && bus_req.we && cls == cls_io) begin
        for (int b = 0; b < 4; b++) begin
          if (bus_req.be[b]) m_mem[bus_req.addr.ctx][io][8*b +: 8] = bus_req.wdata[8*b +: 8];
        end
      end
      if (ctrl_evt.trigger && ctrl_evt.true_done &&
          ctrl_evt.pointer_context == ctrl_evt.running_context) begin
        seen_collide = 1'b1;
      end
      // Trigger wins over done on the same context
      for (int c = 0; c < n_context; c++) begin
        if (ctrl_evt.trigger && int'(ctrl_evt.pointer_context) == c) begin
          m_busy[c] = 1'b1;
        end else if (ctrl_evt.true_done && int'(ctrl_evt.running_context) == c) begin
          m_busy[c] = 1'b0;
        end
      end
      if (rd && cls == cls_finished) begin
        m_fin = '0;
      end else if (ctrl_evt.true_done && m_fin < 2'd2) begin
        m_fin = m_fin + 2'd1;
      end
      if (m_done_q) m_running = m_running + 8'd1;
      m_done_q = ctrl_evt.true_done;
    end
  endtask

  // Outputs here still reflect the state left by the previous edge
  task automatic tick();
    int i;
    @(posedge clk);
    check_count++;
    if (rdata !== m_rdata) begin
      $display("[FAIL] %s: expected %h, actual %h", m_rd_name, m_rdata, rdata);
      err_count++;
    end
    for (i = 0; i < n_io_regs; i++) begin
      if (params[i] !== m_mem[ctrl_evt.running_context][i]) begin
        $display("[FAIL] params_o[%0d]: expected %h, actual %h", i,
                 m_mem[ctrl_evt.running_context][i], params[i]);
        err_count++;
      end
    end
    update_model();
  endtask

  task automatic drive_random();
    int unsigned op;
    bus_req_t    r;
    ctrl_evt_t   e;
    op = $urandom_range(9, 0);
    r  = '0;
    e  = '0;
    e.is_critical     = ($urandom_range(3, 0) == 0);
    e.full_context    = ($urandom_range(3, 0) == 0);
    e.pointer_context = ctx_t'($urandom_range(n_context - 1, 0));
    e.running_context = ctx_t'($urandom_range(n_context - 1, 0));
    r.addr.ctx        = ctx_t'($urandom_range(n_context - 1, 0));
    case (op)
      0, 1: begin
        r.req      = 1'b1;
        r.addr.idx = reg_idx_t'($urandom_range(31, 0));
      end
      2, 3: begin
        r.req      = 1'b1;
        r.we       = 1'b1;
        r.addr.idx = ($urandom_range(3, 0) == 0) ? reg_idx_t'($urandom_range(31, 0))
                                                  : reg_idx_t'(8 + $urandom_range(7, 0));
        r.wdata    = data_t'($urandom);
        r.be       = be_t'($urandom_range(15, 0));
      end
      4, 5, 6: begin
        r.req      = 1'b1;
        r.addr.idx = reg_acquire;
      end
      7, 8: begin
        e.trigger   = ($urandom_range(1, 0) == 1);
        e.true_done = ($urandom_range(1, 0) == 1);
      end
      default: r = '0;
    endcase
    bus_req  <= r;
    ctrl_evt <= e;
  endtask

  task automatic drive_read(int ctx, int idx);
    bus_req_t r;
    r          = '0;
    r.req      = 1'b1;
    r.addr.ctx = ctx_t'(ctx);
    r.addr.idx = reg_idx_t'(idx);
    bus_req  <= r;
    ctrl_evt <= '0;
  endtask

  initial begin
    void'($urandom(70506));
    err_count    = 0;
    assert_fails = 0;
    check_count  = 0;
    seen_wrap    = 1'b0;
    seen_sat     = 1'b0;
    seen_collide = 1'b0;
    rst_n    <= 1'b0;
    clear    <= 1'b0;
    bus_req  <= '0;
    ctrl_evt <= '0;
    reset_model();
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    // Random traffic until id wrap, finished saturation and a collision are seen
    cycles = 0;
    while (!(seen_wrap && seen_sat && seen_collide) && cycles < max_cycles) begin
      tick();
      drive_random();
      cycles++;
    end
    if (!(seen_wrap && seen_sat && seen_collide)) begin
      $display("Timeout: random phase did not reach all scenarios in %0d cycles", max_cycles);
      err_count++;
    end

    tick();
    clear    <= 1'b1;
    bus_req  <= '0;
    ctrl_evt <= '0;
    tick();
    clear <= 1'b0;
    for (int c = 0; c < n_context; c++) begin
      for (int idx = 1; idx < 16; idx++) begin
        tick();
        drive_read(c, idx);
      end
    end

    repeat (500) begin
      tick();
      drive_random();
    end
    tick();
    bus_req  <= '0;
    ctrl_evt <= '0;
    tick();

    assert_fails = i_hwpe_regfile_top.i_hwpe_regfile_chk.fail_count;
    $display("Checked %0d cycles, %0d errors, %0d assertion failures",
             check_count, err_count, assert_fails);
    if (err_count == 0 && assert_fails == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- files.f
logic/regfile_pkg.sv
logic/regfile_access.sv
logic/job_id_tracker.sv
logic/context_status.sv
logic/param_store.sv
logic/hwpe_regfile_top.sv
dv/hwpe_regfile_chk.sv
dv/tb_hwpe_regfile.sv

//--- logic/context_status.sv
// Context status and finished jobs counter
// Tracks which contexts hold a triggered job and counts completed jobs
// until the host reads FINISHED
`timescale 1ns/10ps

module context_status (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  regfile_pkg::ctrl_evt_t evt_i,
  input  logic                   finished_rd_i,
  output regfile_pkg::data_t     status_word_o,
  output logic [1:0]             finished_cnt_o
);
  import regfile_pkg::*;

  logic [n_context-1:0] busy_q;
  logic [1:0]           finished_q;

  // Trigger has priority over done on the same context
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= '0;
    end else if (clear_i) begin
      busy_q <= '0;
    end else begin
      for (int c = 0; c < n_context; c++) begin
        if (evt_i.trigger && (evt_i.pointer_context == ctx_t'(c))) begin
          busy_q[c] <= 1'b1;
        end else if (evt_i.true_done && (evt_i.running_context == ctx_t'(c))) begin
          busy_q[c] <= 1'b0;
        end
      end
    end
  end

  // One byte per context, upper bytes stay zero
  always_comb begin
    status_word_o = '0;
    for (int c = 0; c < n_context; c++) begin
      status_word_o[8*c +: 8] = {7'b0, busy_q[c]};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      finished_q <= '0;
    end else if (clear_i || finished_rd_i) begin
      finished_q <= '0;
    end else if (evt_i.true_done && (finished_q < 2'd2)) begin
      finished_q <= finished_q + 1'b1;
    end
  end

  assign finished_cnt_o = finished_q;

endmodule

//--- logic/hwpe_regfile_top.sv
// Processing engine control register file
// Connects address decode, job id tracking, context status and
// parameter storage behind a single host word bus
`timescale 1ns/10ps

module hwpe_regfile_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  regfile_pkg::bus_req_t  req_i,
  input  regfile_pkg::ctrl_evt_t evt_i,
  output regfile_pkg::data_t     rdata_o,
  output regfile_pkg::params_t   params_o
);
  import regfile_pkg::*;

  logic       acquire_rd;
  logic       finished_rd;
  logic       io_we;
  io_idx_t    io_idx;
  ctx_t       io_ctx;
  data_t      acquire_rdata;
  job_id_t    running_job;
  data_t      status_word;
  logic [1:0] finished_cnt;
  data_t      io_rdata;

  regfile_access i_regfile_access (
    .clk_i           ( clk_i         ),
    .rst_ni          ( rst_ni        ),
    .clear_i         ( clear_i       ),
    .req_i           ( req_i         ),
    .acquire_rdata_i ( acquire_rdata ),
    .running_job_i   ( running_job   ),
    .status_word_i   ( status_word   ),
    .finished_cnt_i  ( finished_cnt  ),
    .io_rdata_i      ( io_rdata      ),
    .acquire_rd_o    ( acquire_rd    ),
    .finished_rd_o   ( finished_rd   ),
    .io_we_o         ( io_we         ),
    .io_idx_o        ( io_idx        ),
    .io_ctx_o        ( io_ctx        ),
    .rdata_o         ( rdata_o       )
  );

  job_id_tracker i_job_id_tracker (
    .clk_i           ( clk_i         ),
    .rst_ni          ( rst_ni        ),
    .clear_i         ( clear_i       ),
    .acquire_rd_i    ( acquire_rd    ),
    .evt_i           ( evt_i         ),
    .acquire_rdata_o ( acquire_rdata ),
    .running_job_o   ( running_job   )
  );

  context_status i_context_status (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .clear_i        ( clear_i      ),
    .evt_i          ( evt_i        ),
    .finished_rd_i  ( finished_rd  ),
    .status_word_o  ( status_word  ),
    .finished_cnt_o ( finished_cnt )
  );

  // Host reads and writes share the decoded index and context
  param_store i_param_store (
    .clk_i         ( clk_i                 ),
    .rst_ni        ( rst_ni                ),
    .clear_i       ( clear_i               ),
    .io_we_i       ( io_we                 ),
    .io_ctx_i      ( io_ctx                ),
    .io_idx_i      ( io_idx                ),
    .wdata_i       ( req_i.wdata           ),
    .be_i          ( req_i.be              ),
    .rd_ctx_i      ( io_ctx                ),
    .rd_idx_i      ( io_idx                ),
    .running_ctx_i ( evt_i.running_context ),
    .io_rdata_o    ( io_rdata              ),
    .params_o      ( params_o              )
  );

endmodule

//--- logic/job_id_tracker.sv
// Job id tracker
// Hands out offload job ids on ACQUIRE reads and counts finished jobs
// to follow the id of the running job
`timescale 1ns/10ps

module job_id_tracker (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   acquire_rd_i,
  input  regfile_pkg::ctrl_evt_t evt_i,
  output regfile_pkg::data_t     acquire_rdata_o,
  output regfile_pkg::job_id_t   running_job_o
);
  import regfile_pkg::*;

  job_id_t offload_id_q;
  job_id_t running_id_q;
  data_t   acquire_rdata_q;
  logic    done_q;

  // Acquire response, the id advances only when one is handed out
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acquire_rdata_q <= '0;
      offload_id_q    <= '0;
    end else if (clear_i) begin
      acquire_rdata_q <= '0;
      offload_id_q    <= '0;
    end else if (acquire_rd_i) begin
      if (evt_i.is_critical) begin
        acquire_rdata_q <= resp_other_offloading;
      end else if (evt_i.full_context) begin
        acquire_rdata_q <= resp_all_busy;
      end else begin
        acquire_rdata_q <= data_t'(offload_id_q);
        offload_id_q    <= offload_id_q + 1'b1;
      end
    end
  end

  // Running id follows done one cycle late and wraps
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q       <= 1'b0;
      running_id_q <= '0;
    end else if (clear_i) begin
      done_q       <= 1'b0;
      running_id_q <= '0;
    end else begin
      done_q <= evt_i.true_done;
      if (done_q) begin
        running_id_q <= running_id_q + 1'b1;
      end
    end
  end

  assign acquire_rdata_o = acquire_rdata_q;
  assign running_job_o   = running_id_q;

endmodule

//--- logic/param_store.sv
// Job parameter store
// One set of parameter words per context with byte enable writes,
// a read port for the host and the running context's set for the datapath
`timescale 1ns/10ps

module param_store (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 clear_i,
  input  logic                 io_we_i,
  input  regfile_pkg::ctx_t    io_ctx_i,
  input  regfile_pkg::io_idx_t io_idx_i,
  input  regfile_pkg::data_t   wdata_i,
  input  regfile_pkg::be_t     be_i,
  input  regfile_pkg::ctx_t    rd_ctx_i,
  input  regfile_pkg::io_idx_t rd_idx_i,
  input  regfile_pkg::ctx_t    running_ctx_i,
  output regfile_pkg::data_t   io_rdata_o,
  output regfile_pkg::params_t params_o
);
  import regfile_pkg::*;

  params_t mem_q [n_context];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int c = 0; c < n_context; c++) begin
        mem_q[c] <= '0;
      end
    end else if (clear_i) begin
      for (int c = 0; c < n_context; c++) begin
        mem_q[c] <= '0;
      end
    end else if (io_we_i) begin
      // Merge only the enabled bytes
      for (int b = 0; b < data_w/8; b++) begin
        if (be_i[b]) begin
          mem_q[io_ctx_i][io_idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  assign io_rdata_o = mem_q[rd_ctx_i][rd_idx_i];

  // Datapath always sees the running context
  assign params_o = mem_q[running_ctx_i];

endmodule

//--- logic/regfile_access.sv
// Register file access block
// Decodes host addresses into register classes, raises the access strobes
// and returns the read data one cycle after the request
`timescale 1ns/10ps

module regfile_access (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  regfile_pkg::bus_req_t req_i,
  input  regfile_pkg::data_t    acquire_rdata_i,
  input  regfile_pkg::job_id_t  running_job_i,
  input  regfile_pkg::data_t    status_word_i,
  input  logic [1:0]            finished_cnt_i,
  input  regfile_pkg::data_t    io_rdata_i,
  output logic                  acquire_rd_o,
  output logic                  finished_rd_o,
  output logic                  io_we_o,
  output regfile_pkg::io_idx_t  io_idx_o,
  output regfile_pkg::ctx_t     io_ctx_o,
  output regfile_pkg::data_t    rdata_o
);
  import regfile_pkg::*;

  reg_class_t cls_d;
  reg_class_t cls_q;
  reg_idx_t   io_off;
  logic       rd_req;
  data_t      snap_d;
  data_t      snap_q;

  // Address decode
  always_comb begin
    io_off = req_i.addr.idx - reg_io_base;
    case (req_i.addr.idx)
      reg_trigger, reg_softclear: cls_d = cls_zero;
      reg_acquire:                cls_d = cls_acquire;
      reg_finished:               cls_d = cls_finished;
      reg_status:                 cls_d = cls_status;
      reg_running_job:            cls_d = cls_running;
      default: begin
        if ((req_i.addr.idx >= reg_io_base) && (io_off < reg_idx_t'(n_io_regs))) begin
          cls_d = cls_io;
        end else begin
          cls_d = cls_unknown;
        end
      end
    endcase
  end

  assign rd_req        = req_i.req & ~req_i.we;
  assign acquire_rd_o  = rd_req && (cls_d == cls_acquire);
  assign finished_rd_o = rd_req && (cls_d == cls_finished);
  assign io_we_o       = req_i.req && req_i.we && (cls_d == cls_io);
  assign io_idx_o      = io_off[io_idx_w-1:0];
  assign io_ctx_o      = req_i.addr.ctx;

  // Value sampled at the request edge, acquire comes from the tracker
  always_comb begin
    case (cls_d)
      cls_finished: snap_d = data_t'(finished_cnt_i);
      cls_status:   snap_d = status_word_i;
      cls_running:  snap_d = data_t'(running_job_i);
      cls_io:       snap_d = io_rdata_i;
      cls_unknown:  snap_d = unknown_rdata;
      default:      snap_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cls_q  <= cls_zero;
      snap_q <= '0;
    end else if (clear_i) begin
      cls_q  <= cls_zero;
      snap_q <= '0;
    end else if (rd_req) begin
      cls_q  <= cls_d;
      snap_q <= snap_d;
    end
  end

  assign rdata_o = (cls_q == cls_acquire) ? acquire_rdata_i : snap_q;

endmodule

//--- logic/regfile_pkg.sv
// Register file package
// Widths, register map, response codes and the bus and controller event types
// shared by the register file blocks
package regfile_pkg;

  localparam int unsigned data_w    = 32;
  localparam int unsigned n_context = 2;
  localparam int unsigned n_io_regs = 8;
  localparam int unsigned reg_idx_w = 5;
  localparam int unsigned ctx_w     = 1;
  localparam int unsigned job_id_w  = 8;
  localparam int unsigned io_idx_w  = $clog2(n_io_regs);

  typedef logic [data_w-1:0]    data_t;
  typedef logic [reg_idx_w-1:0] reg_idx_t;
  typedef logic [ctx_w-1:0]     ctx_t;
  typedef logic [job_id_w-1:0]  job_id_t;
  typedef logic [data_w/8-1:0]  be_t;
  typedef logic [io_idx_w-1:0]  io_idx_t;

  // Register indices inside one context window
  localparam reg_idx_t reg_trigger     = reg_idx_t'(0);
  localparam reg_idx_t reg_acquire     = reg_idx_t'(1);
  localparam reg_idx_t reg_finished    = reg_idx_t'(2);
  localparam reg_idx_t reg_status      = reg_idx_t'(3);
  localparam reg_idx_t reg_running_job = reg_idx_t'(4);
  localparam reg_idx_t reg_softclear   = reg_idx_t'(5);
  localparam reg_idx_t reg_io_base     = reg_idx_t'(8);

  localparam data_t resp_other_offloading = data_t'(-2);
  localparam data_t resp_all_busy         = data_t'(-1);
  localparam data_t unknown_rdata         = 32'hDEAD_BEEF;

  // Context field sits above the register index
  typedef struct packed {
    ctx_t     ctx;
    reg_idx_t idx;
  } addr_t;

  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    data_t wdata;
    be_t   be;
  } bus_req_t;

  typedef struct packed {
    logic is_critical;
    logic full_context;
    logic trigger;
    logic true_done;
    ctx_t pointer_context;
    ctx_t running_context;
  } ctrl_evt_t;

  typedef enum logic [2:0] {
    cls_acquire,
    cls_finished,
    cls_status,
    cls_running,
    cls_zero,
    cls_io,
    cls_unknown
  } reg_class_t;

  typedef data_t [n_io_regs-1:0] params_t;

endpackage
